//--- Bender.yml
package:
  name: neo_cart_loader

sources:
  - src/neo_loader_pkg.sv
  - src/neo_header_parser.sv
  - src/neo_region_tracker.sv
  - src/neo_tile_buffer.sv
  - src/sdram_toggle_port.sv
  - src/neo_port_dispatch.sv
  - src/neo_cart_loader.sv
  - target: simulation
    files:
      - testbench/tb_neo_cart_loader.sv

//--- neo_cart_loader.f
src/neo_loader_pkg.sv
src/neo_header_parser.sv
src/neo_region_tracker.sv
src/neo_tile_buffer.sv
src/sdram_toggle_port.sv
src/neo_port_dispatch.sv
src/neo_cart_loader.sv
testbench/tb_neo_cart_loader.sv

//--- src/neo_cart_loader.sv
module neo_cart_loader
	import neo_loader_pkg::*;
(
	input  logic      CLK_48M,
	input  logic      pll_locked,
	input  ioctl_t    ioctl,
	output logic      port1_req,
	input  logic      port1_ack,
	output port1_wr_t port1_wr,
	output logic      port2_req,
	input  logic      port2_ack,
	output port2_wr_t port2_wr
);

	region_sizes_t sizes;
	region_e       region;
	logic [26:0]   offset;
	logic          page_ready;
	page_info_t    page_info;
	logic [5:0]    word_index;
	logic [15:0]   word;

	neo_header_parser parser_inst (
		.CLK_48M    (CLK_48M),
		.pll_locked (pll_locked),
		.ioctl      (ioctl),
		.sizes      (sizes)
	);

	neo_region_tracker tracker_inst (
		.CLK_48M    (CLK_48M),
		.pll_locked (pll_locked),
		.ioctl      (ioctl),
		.sizes      (sizes),
		.region     (region),
		.offset     (offset)
	);

	neo_tile_buffer buffer_inst (
		.CLK_48M    (CLK_48M),
		.pll_locked (pll_locked),
		.ioctl      (ioctl),
		.region     (region),
		.offset     (offset),
		.page_ready (page_ready),
		.page_info  (page_info),
		.word_index (word_index),
		.word       (word)
	);

	neo_port_dispatch dispatch_inst (
		.CLK_48M    (CLK_48M),
		.pll_locked (pll_locked),
		.sizes      (sizes),
		.page_ready (page_ready),
		.page_info  (page_info),
		.word_index (word_index),
		.word       (word),
		.port1_req  (port1_req),
		.port1_ack  (port1_ack),
		.port1_wr   (port1_wr),
		.port2_req  (port2_req),
		.port2_ack  (port2_ack),
		.port2_wr   (port2_wr)
	);

endmodule

//--- src/neo_header_parser.sv
module neo_header_parser
	import neo_loader_pkg::*;
(
	input  logic          CLK_48M,
	input  logic          pll_locked,
	input  ioctl_t        ioctl,
	output region_sizes_t sizes
);

	logic       field_wr;
	logic [4:0] rel;     // Byte index inside the size table
	logic [2:0] field;
	logic [1:0] lane;

	// Little-endian byte into a 32-bit field, bits above 26 dropped
	function automatic logic [26:0] put_lane(logic [26:0] f, logic [1:0] l, logic [7:0] b);
		logic [31:0] w;
		w = {5'd0, f};
		w[l*8 +: 8] = b;
		return w[26:0];
	endfunction

	assign field_wr = cart_download(ioctl) && ioctl.wr &&
		ioctl.addr >= SIZE_FIELD_FIRST && ioctl.addr <= SIZE_FIELD_LAST;
	assign rel = 5'(ioctl.addr - SIZE_FIELD_FIRST);
	assign field = rel[4:2];
	assign lane = rel[1:0];

	always_ff @(posedge CLK_48M or negedge pll_locked) begin
		if (!pll_locked) begin
			sizes <= '0;
		end else if (field_wr) begin
			case (field)
				3'd0: sizes.p <= put_lane(sizes.p, lane, ioctl.dout);
				3'd1: sizes.s <= put_lane(sizes.s, lane, ioctl.dout);
				3'd2: sizes.m <= put_lane(sizes.m, lane, ioctl.dout);
				3'd3: sizes.v1 <= put_lane(sizes.v1, lane, ioctl.dout);
				3'd4: sizes.v2 <= put_lane(sizes.v2, lane, ioctl.dout);
				3'd5: sizes.c <= put_lane(sizes.c, lane, ioctl.dout);
				default: ;
			endcase
		end
	end

endmodule

//--- src/neo_loader_pkg.sv
package neo_loader_pkg;

	localparam int HEADER_BYTES = 4096;
	localparam int PAGE_BYTES = 128;           // One staging page
	localparam int SIZE_FIELD_FIRST = 4;
	localparam int SIZE_FIELD_LAST = 27;

	localparam logic [26:0] FIX_BASE = 27'hE00000;   // S region on port 1
	localparam logic [26:0] MROM_BASE = 27'hF00000;  // M region on port 1

	localparam logic [7:0] IDX_CART = 8'd1;
	localparam logic [7:0] IDX_CART_NO_ADPCM = 8'd2;

	// Regions in file order
	typedef enum logic [2:0] {
		REG_P,
		REG_S,
		REG_M,
		REG_V1,
		REG_V2,
		REG_C,
		REG_DONE
	} region_e;

	typedef struct packed {
		logic        downl;
		logic [7:0]  index;
		logic        wr;
		logic [26:0] addr;
		logic [7:0]  dout;
	} ioctl_t;

	typedef struct packed {
		logic [26:0] p;
		logic [26:0] s;
		logic [26:0] m;
		logic [26:0] v1;
		logic [26:0] v2;
		logic [26:0] c;
	} region_sizes_t;

	typedef struct packed {
		region_e     region;
		logic [26:0] base;   // Offset of the page's first byte in its region
	} page_info_t;

	typedef struct packed {
		logic [22:0] addr;
		logic [15:0] data;
	} port1_wr_t;

	typedef struct packed {
		logic [24:0] addr;
		logic [15:0] data;
	} port2_wr_t;

	function automatic logic cart_download(ioctl_t io);
		return io.downl && (io.index == IDX_CART || io.index == IDX_CART_NO_ADPCM);
	endfunction

endpackage

//--- src/neo_port_dispatch.sv
module neo_port_dispatch
	import neo_loader_pkg::*;
(
	input  logic          CLK_48M,
	input  logic          pll_locked,
	input  region_sizes_t sizes,
	input  logic          page_ready,
	input  page_info_t    page_info,
	output logic [5:0]    word_index,
	input  logic [15:0]   word,
	output logic          port1_req,
	input  logic          port1_ack,
	output port1_wr_t     port1_wr,
	output logic          port2_req,
	input  logic          port2_ack,
	output port2_wr_t     port2_wr
);

	typedef enum logic [1:0] {IDLE, FETCH, ISSUE, WAIT} state_e;

	state_e      state;
	logic        to_port1;
	logic        busy1, busy2;
	logic        busy;
	logic [26:0] region_base;
	logic [26:0] byte_addr;
	port1_wr_t   payload1;
	port2_wr_t   payload2;

	assign to_port1 = page_info.region inside {REG_P, REG_S, REG_M};
	assign busy = to_port1 ? busy1 : busy2;

	always_comb begin
		case (page_info.region)
			REG_S: region_base = FIX_BASE;
			REG_M: region_base = MROM_BASE;
			REG_V1: region_base = sizes.c;            // ADPCM sits above sprites
			REG_V2: region_base = sizes.c + sizes.v1;
			default: region_base = '0;
		endcase
	end

	assign byte_addr = page_info.base + region_base + {20'd0, word_index, 1'b0};
	assign payload1 = '{addr: byte_addr[23:1], data: word};
	assign payload2 = '{addr: byte_addr[25:1], data: word};

	always_ff @(posedge CLK_48M or negedge pll_locked) begin
		if (!pll_locked) begin
			state <= IDLE;
			word_index <= '0;
		end else begin
			case (state)
				IDLE: if (page_ready) begin
					word_index <= '0;
					state <= FETCH;
				end
				FETCH: state <= ISSUE;  // Buffer read in flight
				ISSUE: state <= WAIT;
				WAIT: if (!busy) begin
					if (&word_index) begin
						state <= IDLE;
					end else begin
						word_index <= word_index + 6'd1;
						state <= FETCH;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	sdram_toggle_port #(.payload_t(port1_wr_t)) port1_inst (
		.CLK_48M    (CLK_48M),
		.pll_locked (pll_locked),
		.start      (state == ISSUE && to_port1),
		.payload    (payload1),
		.busy       (busy1),
		.req        (port1_req),
		.ack        (port1_ack),
		.wr         (port1_wr)
	);

	sdram_toggle_port #(.payload_t(port2_wr_t)) port2_inst (
		.CLK_48M    (CLK_48M),
		.pll_locked (pll_locked),
		.start      (state == ISSUE && !to_port1),
		.payload    (payload2),
		.busy       (busy2),
		.req        (port2_req),
		.ack        (port2_ack),
		.wr         (port2_wr)
	);

endmodule

//--- src/neo_region_tracker.sv
module neo_region_tracker
	import neo_loader_pkg::*;
(
	input  logic          CLK_48M,
	input  logic          pll_locked,
	input  ioctl_t        ioctl,
	input  region_sizes_t sizes,
	output region_e       region,
	output logic [26:0]   offset
);

	logic [26:0] cur_size;
	logic [26:0] offset_next;

	function automatic logic [26:0] size_of(region_sizes_t s, logic [2:0] r);
		case (r)
			3'd0: return s.p;
			3'd1: return s.s;
			3'd2: return s.m;
			3'd3: return s.v1;
			3'd4: return s.v2;
			3'd5: return s.c;
			default: return '0;
		endcase
	endfunction

	// First region at or after 'from' that holds data
	function automatic region_e next_region(region_sizes_t s, logic [3:0] from);
		region_e r;
		r = REG_DONE;
		for (int i = 5; i >= 0; i--) begin
			if (i >= from && size_of(s, 3'(i)) != '0)
				r = region_e'(i);
		end
		return r;
	endfunction

	assign cur_size = size_of(sizes, region);
	assign offset_next = offset + 27'd1;

	always_ff @(posedge CLK_48M or negedge pll_locked) begin
		if (!pll_locked) begin
			region <= REG_P;
			offset <= '0;
		end else if (cart_download(ioctl) && ioctl.wr) begin
			if (ioctl.addr < HEADER_BYTES) begin
				region <= next_region(sizes, 4'd0);  // Restart while header streams in
				offset <= '0;
			end else if (offset_next == cur_size) begin
				region <= next_region(sizes, {1'b0, region} + 4'd1);
				offset <= '0;
			end else begin
				offset <= offset_next;
			end
		end
	end

endmodule

//--- src/neo_tile_buffer.sv
module neo_tile_buffer
	import neo_loader_pkg::*;
(
	input  logic        CLK_48M,
	input  logic        pll_locked,
	input  ioctl_t      ioctl,
	input  region_e     region,
	input  logic [26:0] offset,
	output logic        page_ready,
	output page_info_t  page_info,
	input  logic [5:0]  word_index,
	output logic [15:0] word
);

	// Two pages of 64 words, byte writable
	logic [1:0][7:0] mem [PAGE_BYTES];

	logic       fill_page;  // Page being filled, the other one drains
	logic       accept;
	logic       last_byte;
	logic       skip_adpcm;
	logic [6:0] a;
	logic [6:0] pos;

	assign a = offset[6:0];
	assign skip_adpcm = ioctl.index == IDX_CART_NO_ADPCM &&
		(region == REG_V1 || region == REG_V2);
	assign accept = cart_download(ioctl) && ioctl.wr && ioctl.addr >= HEADER_BYTES &&
		region != REG_DONE && !skip_adpcm;
	assign last_byte = a == 7'(PAGE_BYTES - 1);

	always_comb begin
		case (region)
			REG_S: pos = {a[6], a[5], a[2], a[1], a[0], ~a[4], a[3]};   // FIX tiles
			REG_C: pos = {a[5], a[4], a[3], a[2], ~a[6], a[0], a[1]};   // Sprite tiles
			default: pos = a;
		endcase
	end

	always_ff @(posedge CLK_48M) begin
		if (accept)
			mem[{fill_page, pos[6:1]}][pos[0]] <= ioctl.dout;
		word <= mem[{~fill_page, word_index}];
	end

	always_ff @(posedge CLK_48M) begin
		if (accept && last_byte) begin
			page_info.region <= region;
			page_info.base <= {offset[26:7], 7'd0};
		end
	end

	always_ff @(posedge CLK_48M or negedge pll_locked) begin
		if (!pll_locked) begin
			fill_page <= 1'b0;
			page_ready <= 1'b0;
		end else begin
			page_ready <= accept && last_byte;
			if (accept && last_byte)
				fill_page <= ~fill_page;
		end
	end

endmodule

//--- src/sdram_toggle_port.sv
module sdram_toggle_port #(
	parameter type payload_t = logic [15:0]
) (
	input  logic     CLK_48M,
	input  logic     pll_locked,
	input  logic     start,
	input  payload_t payload,
	output logic     busy,
	output logic     req,
	input  logic     ack,
	output payload_t wr
);

	// Address and data held while the request is open
	always_ff @(posedge CLK_48M) begin
		if (start && !busy)
			wr <= payload;
	end

	always_ff @(posedge CLK_48M or negedge pll_locked) begin
		if (!pll_locked) begin
			req <= 1'b0;
			busy <= 1'b0;
		end else if (busy) begin
			if (ack == req)
				busy <= 1'b0;   // Controller caught up
		end else if (start) begin
			req <= ~req;
			busy <= 1'b1;
		end
	end

endmodule

//--- testbench/tb_neo_cart_loader.sv
module tb_neo_cart_loader
	import neo_loader_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [31:0] SEED = 32'hb4c4_0990;

	logic        CLK_48M;
	logic        pll_locked;
	ioctl_t      ioctl;
	logic        port1_req, port1_ack;
	logic        port2_req, port2_ack;
	port1_wr_t   port1_wr;
	port2_wr_t   port2_wr;

	logic [15:0] exp1 [int];   // Expected words by word address
	logic [15:0] exp2 [int];
	int          cnt1 [int];
	int          cnt2 [int];
	int          writes1, writes2, total1, total2;
	int          errors;
	bit          first_page_done;
	logic        req1_q, req2_q;

	neo_cart_loader neo_cart_loader_inst (
		.CLK_48M    (CLK_48M),
		.pll_locked (pll_locked),
		.ioctl      (ioctl),
		.port1_req  (port1_req),
		.port1_ack  (port1_ack),
		.port1_wr   (port1_wr),
		.port2_req  (port2_req),
		.port2_ack  (port2_ack),
		.port2_wr   (port2_wr)
	);

	always #50 CLK_48M = ~CLK_48M;

	// Download 0 has an empty V2 and download 1 uses index 2
	function automatic int region_size(int dl, int r);
		if (dl == 0) begin
			case (r)
				0: return 256;
				1: return 256;
				2: return 128;
				3: return 256;
				4: return 0;
				default: return 512;
			endcase
		end
		case (r)
			2: return 0;
			5: return 256;
			default: return 128;
		endcase
	endfunction

	function automatic logic [26:0] region_base(int dl, int r);
		case (r)
			1: return FIX_BASE;
			2: return MROM_BASE;
			3: return 27'(region_size(dl, 5));
			4: return 27'(region_size(dl, 5) + region_size(dl, 3));
			default: return '0;
		endcase
	endfunction

	function automatic logic [6:0] shuffle(int r, logic [6:0] a);
		case (r)
			1: return {a[6], a[5], a[2], a[1], a[0], ~a[4], a[3]};
			5: return {a[5], a[4], a[3], a[2], ~a[6], a[0], a[1]};
			default: return a;
		endcase
	endfunction

	function automatic bit addr_known(int port, int addr);
		return port == 1 ? exp1.exists(addr) : exp2.exists(addr);
	endfunction

	function automatic logic [15:0] expected_word(int port, int addr);
		if (!addr_known(port, addr))
			return 'x;
		return port == 1 ? exp1[addr] : exp2[addr];
	endfunction

	// Little-endian size table at bytes 4 to 27 and random filler elsewhere
	function automatic logic [7:0] header_byte(int dl, int a);
		int rel;
		rel = a - SIZE_FIELD_FIRST;
		if (a >= SIZE_FIELD_FIRST && a <= SIZE_FIELD_LAST)
			return 8'(region_size(dl, rel / 4) >> (8 * (rel % 4)));
		return 8'($urandom);
	endfunction

	task automatic model_byte(int dl, int r, logic [26:0] o, logic [7:0] b);
		logic [6:0]  pos;
		logic [26:0] byte_addr;
		logic [15:0] v;
		int          w;
		if (dl == 1 && (r == 3 || r == 4))
			return;   // ADPCM dropped
		pos = shuffle(r, o[6:0]);
		byte_addr = region_base(dl, r) + {o[26:7], 7'd0} + {20'd0, pos[6:1], 1'b0};
		w = int'(byte_addr[26:1]);
		v = expected_word(r < 3 ? 1 : 2, w);
		if (!addr_known(r < 3 ? 1 : 2, w))
			v = '0;
		if (pos[0])
			v[15:8] = b;
		else
			v[7:0] = b;
		if (r < 3)
			exp1[w] = v;
		else
			exp2[w] = v;
	endtask

	task automatic send_byte(logic [7:0] index, int addr, logic [7:0] b);
		ioctl.downl = 1'b1;
		ioctl.index = index;
		ioctl.addr = 27'(addr);
		ioctl.dout = b;
		ioctl.wr = 1'b1;
		@(negedge CLK_48M);
		ioctl.wr = 1'b0;
		repeat (3) @(negedge CLK_48M);   // One byte every 4 cycles
	endtask

	task automatic check_all_written();
		foreach (exp1[k]) begin
			assert (cnt1.exists(k) && cnt1[k] == 1) else begin
				errors++;
				$display("Port 1 word %h was not written exactly once", k);
			end
		end
		foreach (exp2[k]) begin
			assert (cnt2.exists(k) && cnt2[k] == 1) else begin
				errors++;
				$display("Port 2 word %h was not written exactly once", k);
			end
		end
	endtask

	task automatic run_download(int dl);
		logic [7:0] index;
		logic [7:0] b;
		int         addr;
		index = dl == 0 ? IDX_CART : IDX_CART_NO_ADPCM;
		exp1.delete();
		exp2.delete();
		cnt1.delete();
		cnt2.delete();
		writes1 = 0;
		writes2 = 0;
		for (addr = 0; addr < HEADER_BYTES; addr++)
			send_byte(index, addr, header_byte(dl, addr));
		for (int r = 0; r < 6; r++) begin
			for (int o = 0; o < region_size(dl, r); o++) begin
				b = 8'($urandom);
				model_byte(dl, r, 27'(o), b);
				if (addr == HEADER_BYTES + PAGE_BYTES - 1)
					first_page_done = 1'b1;
				send_byte(index, addr, b);
				addr++;
			end
		end
		ioctl.downl = 1'b0;
		while (writes1 < exp1.num() || writes2 < exp2.num())
			@(negedge CLK_48M);
		repeat (16) @(negedge CLK_48M);   // Room for stray writes
		check_all_written();
	endtask

	// A req flip marks a new write
	always @(posedge CLK_48M) begin
		if (pll_locked && port1_req != req1_q) begin
			cnt1[int'(port1_wr.addr)] = cnt1.exists(int'(port1_wr.addr)) ?
				cnt1[int'(port1_wr.addr)] + 1 : 1;
			writes1++;
			total1++;
		end
		if (pll_locked && port2_req != req2_q) begin
			cnt2[int'(port2_wr.addr)] = cnt2.exists(int'(port2_wr.addr)) ?
				cnt2[int'(port2_wr.addr)] + 1 : 1;
			writes2++;
			total2++;
		end
		req1_q <= port1_req;
		req2_q <= port2_req;
	end

	req_idle_a: assert property (@(posedge CLK_48M) disable iff (!pll_locked)
		!first_page_done |-> !port1_req && !port2_req)
		else begin
			errors++;
			$display("[ERROR] port1_req %h, port2_req %h before the first page", port1_req,
				port2_req);
		end

	p1_addr_a: assert property (@(posedge CLK_48M) disable iff (!pll_locked)
		$changed(port1_req) |-> addr_known(1, int'(port1_wr.addr)))
		else begin
			errors++;
			$display("Port 1 wrote to unexpected word address %h", port1_wr.addr);
		end

	p1_data_a: assert property (@(posedge CLK_48M) disable iff (!pll_locked)
		$changed(port1_req) && addr_known(1, int'(port1_wr.addr)) |->
		port1_wr.data == expected_word(1, int'(port1_wr.addr)))
		else begin
			errors++;
			$display("[ERROR] port1_wr.data at %h: got %h, expected %h", port1_wr.addr,
				port1_wr.data, expected_word(1, int'(port1_wr.addr)));
		end

	p2_addr_a: assert property (@(posedge CLK_48M) disable iff (!pll_locked)
		$changed(port2_req) |-> addr_known(2, int'(port2_wr.addr)))
		else begin
			errors++;
			$display("Port 2 wrote to unexpected word address %h", port2_wr.addr);
		end

	p2_data_a: assert property (@(posedge CLK_48M) disable iff (!pll_locked)
		$changed(port2_req) && addr_known(2, int'(port2_wr.addr)) |->
		port2_wr.data == expected_word(2, int'(port2_wr.addr)))
		else begin
			errors++;
			$display("[ERROR] port2_wr.data at %h: got %h, expected %h", port2_wr.addr,
				port2_wr.data, expected_word(2, int'(port2_wr.addr)));
		end

	// SDRAM model mirrors req into ack after 1 to 3 cycles
	initial begin
		forever begin
			@(negedge CLK_48M);
			if (pll_locked && port1_req != port1_ack) begin
				repeat (1 + $urandom % 3) @(negedge CLK_48M);
				port1_ack = port1_req;
			end
		end
	end

	initial begin
		forever begin
			@(negedge CLK_48M);
			if (pll_locked && port2_req != port2_ack) begin
				repeat (1 + $urandom % 3) @(negedge CLK_48M);
				port2_ack = port2_req;
			end
		end
	end

	initial begin
		int bytes;
		bytes = 2 * HEADER_BYTES;
		for (int dl = 0; dl < 2; dl++) begin
			for (int r = 0; r < 6; r++)
				bytes += region_size(dl, r);
		end
		repeat (bytes * 4 * 2 + 1000) @(posedge CLK_48M);
		$display("Timeout, the loader did not finish its writes in time");
		$display("Simulation failed");
		$finish;
	end

	initial begin
		void'($urandom(SEED));
		CLK_48M = 1'b0;
		pll_locked = 1'b0;
		ioctl = '0;
		port1_ack = 1'b0;
		port2_ack = 1'b0;
		first_page_done = 1'b0;
		errors = 0;
		total1 = 0;
		total2 = 0;
		repeat (5) @(negedge CLK_48M);
		pll_locked = 1'b1;
		repeat (2) @(negedge CLK_48M);
		run_download(0);
		run_download(1);
		$display("Port 1 writes %0d, port 2 writes %0d, errors %0d", total1, total2, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
